// ==== run_sim.sh ====
#!/bin/sh
# build and run the SPI slave testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f spi_slave.f \
   --top-module tb_spi_slave -o sim_spi_slave
status=$?
if [ "$status" -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

out=$(./obj_dir/sim_spi_slave)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
   exit 0
fi
exit 1

// ==== spi_regfile.sv ====
//############################
// byte register file, one write and one read port
// SREGS must be a power of two, 16/32/64
// address bits above log2(SREGS) are dropped, so bursts wrap
// no reset, contents survive ss between transactions
//############################

`timescale 1ns/1ps
`default_nettype none

module spi_regfile #(
   parameter int SREGS = 16   // number of byte registers
) (
   input  wire                              sclk,
   input  wire                              spi_write,
   input  wire  [spi_slave_pkg::ADDR_W-1:0] spi_addr,
   input  wire  [spi_slave_pkg::BYTE_W-1:0] spi_wdata,
   input  wire  [spi_slave_pkg::ADDR_W-1:0] spi_raddr,
   output logic [spi_slave_pkg::BYTE_W-1:0] spi_rdata
);

   import spi_slave_pkg::*;

   localparam int IDX_W = $clog2(SREGS);   // index bits kept from the address

   logic [BYTE_W-1:0] mem [SREGS];
   logic [IDX_W-1:0]  wr_idx;
   logic [IDX_W-1:0]  rd_idx;

   //############################
   // index folding
   //############################

   assign wr_idx = spi_addr[IDX_W-1:0];
   assign rd_idx = spi_raddr[IDX_W-1:0];

   //############################
   // storage
   //############################

   // write lands on the edge that completes the byte
   always_ff @(posedge sclk) begin
      if (spi_write)
         mem[wr_idx] <= spi_wdata;
   end

   // async read, tx shifter samples it on the same edge
   assign spi_rdata = mem[rd_idx];

endmodule

`default_nettype wire

// ==== spi_rx_shift.sv ====
//############################
// mosi deserializer, 7 stored bits plus the live input
// rx_byte is only a full byte on the eighth edge of a byte
// lsbfirst must stay stable for the whole byte
//############################

`timescale 1ns/1ps
`default_nettype none

module spi_rx_shift (
   input  wire                              sclk,
   input  wire                              ss,       // async clear
   input  wire                              shift,    // sample din this edge
   input  wire                              lsbfirst,
   input  wire                              din,
   output logic [spi_slave_pkg::BYTE_W-1:0] rx_byte
);

   import spi_slave_pkg::*;

   logic [BYTE_W-2:0] sreg;   // bits seen so far in this byte

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         sreg <= '0;
      end else if (shift) begin
         if (lsbfirst)
            sreg <= {din, sreg[BYTE_W-2:1]};   // enters at top, walks down
         else
            sreg <= {sreg[BYTE_W-3:0], din};   // enters at bottom, walks up
      end
   end

   // last bit taken straight from the pin, so the write lands on the same edge
   assign rx_byte = lsbfirst ? {din, sreg} : {sreg, din};

endmodule

`default_nettype wire

// ==== spi_slave.f ====
spi_slave_pkg.sv
spi_rx_shift.sv
spi_tx_shift.sv
spi_slave_io.sv
spi_regfile.sv
spi_slave_top.sv
spi_slave_checker.sv
spi_slave_asserts.sv
tb_spi_slave.sv

// ==== spi_slave_asserts.sv ====
//############################
// concurrent checks inside spi_slave_io
// sampled on rising sclk only
//############################

`timescale 1ns/1ps
`default_nettype none

module spi_slave_asserts (
   input wire                                         sclk,
   input wire                                         ss,
   input wire                                         spi_en,
   input wire                                         miso,
   input wire                                         spi_write,
   input wire [$bits(spi_slave_pkg::spi_state_t)-1:0] state
);

   import spi_slave_pkg::*;

   int fails = 0;   // failed assertions, summed into the closing line

   // strobe only in the data phase of a selected slave
   a_write_in_data : assert property (@(posedge sclk)
         !(spi_write && (ss || state != SPI_DATA)))
      else begin
         fails++;
         $error("spi_write high outside the data phase");
      end

   a_miso_gated : assert property (@(posedge sclk) !spi_en |-> !miso)
      else begin
         fails++;
         $error("miso high while spi_en is low");
      end

   // data phase only ends through ss
   a_no_cmd_after_data : assert property (@(posedge sclk) disable iff (ss)
         state == SPI_DATA |=> state != SPI_CMD)
      else begin
         fails++;
         $error("state went from data back to command");
      end

endmodule

bind spi_slave_io spi_slave_asserts u_asserts (
   .sclk      (sclk),
   .ss        (ss),
   .spi_en    (spi_en),
   .miso      (miso),
   .spi_write (spi_write),
   .state     (state)
);

`default_nettype wire

// ==== spi_slave_checker.sv ====
//############################
// watches the SPI pins and keeps its own register model
// assumes lsbfirst and spi_en stay fixed within a transaction
// inputs change only just after rising sclk
// reads of never-written registers count as errors
//############################

`timescale 1ns/1ps
`default_nettype none

module spi_slave_checker #(
   parameter int SREGS = 16
) (
   input  wire sclk,
   input  wire ss,
   input  wire mosi,
   input  wire miso,
   input  wire spi_en,
   input  wire lsbfirst,
   output int  checks,
   output int  errors
);

   import spi_slave_pkg::*;

   logic [BYTE_W-1:0] model   [SREGS];   // expected register contents
   logic              written [SREGS];
   int                edge_cnt;          // edges since ss fell
   logic [BYTE_W-1:0] acc;               // byte being collected from mosi
   logic              cmd_seen;
   logic [OP_W-1:0]   op;
   logic [ADDR_W-1:0] addr;              // address of the byte in flight

   initial begin
      checks   = 0;
      errors   = 0;
      edge_cnt = 0;
      acc      = '0;
      cmd_seen = 1'b0;
      op       = '0;
      addr     = '0;
      for (int i = 0; i < SREGS; i++)
         written[i] = 1'b0;
   end

   task automatic expect_low(input string why);
      checks++;
      if (miso !== 1'b0) begin
         errors++;
         $display("Fail miso: got %h expected %h (%s)", miso, 1'b0, why);
      end
   endtask

   //############################
   // pin decode and compare
   //############################

   always @(posedge sclk) begin
      int   pos;
      int   bi;
      int   idx;
      logic exp_bit;
      pos = edge_cnt % BYTE_W;                    // bit slot within the byte
      bi  = lsbfirst ? pos : BYTE_W - 1 - pos;   // register bit on the wire
      idx = int'(addr) % SREGS;                   // folded like the regfile
      if (ss) begin
         expect_low("slave not selected");
         edge_cnt = 0;
         acc      = '0;
         cmd_seen = 1'b0;
      end else begin
         if (cmd_seen && spi_en && op == SPI_RD) begin
            checks++;
            if (!written[idx]) begin
               errors++;
               $display("read reached register %0d, which was never written", idx);
            end else begin
               exp_bit = model[idx][bi];
               if (miso !== exp_bit) begin
                  errors++;
                  $display("Fail miso: got %h expected %h (reg %0d bit %0d)",
                           miso, exp_bit, idx, bi);
               end
            end
         end else begin
            expect_low("no read in progress");
         end
         if (spi_en)
            acc[bi] = mosi;
         // byte complete on this edge
         if (pos == BYTE_W - 1) begin
            if (!cmd_seen) begin
               op       = acc[BYTE_W-1:ADDR_W];
               addr     = acc[ADDR_W-1:0];
               cmd_seen = 1'b1;
            end else begin
               if (spi_en && op == SPI_WR) begin
                  model[idx]   = acc;
                  written[idx] = 1'b1;
               end
               addr = addr + ADDR_W'(1);   // wraps mod 64
            end
            acc = '0;
         end
         edge_cnt++;
      end
   end

endmodule

`default_nettype wire

// ==== spi_slave_io.sv ====
//############################
// SPI slave transaction logic, mode 0, all on rising sclk
// ss high is the async reset, every transaction starts in idle
// first byte {op, addr}, then data bytes with auto increment
// address wraps mod 64, regfile folds it further
// no back-pressure, ss may rise at any point
//############################

`timescale 1ns/1ps
`default_nettype none

module spi_slave_io (
   input  wire                              sclk,
   input  wire                              ss,
   input  wire                              mosi,
   output logic                             miso,
   input  wire                              spi_en,
   input  wire                              lsbfirst,
   // register file side
   output logic                             spi_write,
   output logic [spi_slave_pkg::ADDR_W-1:0] spi_addr,
   output logic [spi_slave_pkg::BYTE_W-1:0] spi_wdata,
   output logic [spi_slave_pkg::ADDR_W-1:0] spi_raddr,
   input  wire  [spi_slave_pkg::BYTE_W-1:0] spi_rdata
);

   import spi_slave_pkg::*;

   spi_state_t        state;
   logic [2:0]        bit_cnt;     // edge count within a byte
   logic              byte_done;   // this edge completes a byte
   logic [OP_W-1:0]   op_reg;
   logic [ADDR_W-1:0] addr_reg;    // current burst address
   logic [BYTE_W-1:0] rx_byte;
   logic              tx_dout;
   logic              rd_active;

   //############################
   // FSM and bit counter
   //############################

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         state <= SPI_IDLE;
      end else begin
         case (state)
            SPI_IDLE: state <= SPI_CMD;                          // first edge
            SPI_CMD:  state <= byte_done ? SPI_DATA : SPI_CMD;
            SPI_DATA: state <= SPI_DATA;                         // until ss
            default:  state <= SPI_IDLE;
         endcase
      end
   end

   always_ff @(posedge sclk or posedge ss) begin
      if (ss)
         bit_cnt <= '0;
      else
         bit_cnt <= bit_cnt + 3'd1;   // wraps every byte
   end

   assign byte_done = (bit_cnt == 3'd7);

   // command register, address bumps after every data byte
   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         op_reg   <= SPI_WR;
         addr_reg <= '0;
      end else if (byte_done) begin
         if (state == SPI_CMD) begin
            op_reg   <= rx_byte[BYTE_W-1:ADDR_W];
            addr_reg <= rx_byte[ADDR_W-1:0];
         end else if (state == SPI_DATA) begin
            addr_reg <= addr_reg + ADDR_W'(1);   // mod 64
         end
      end
   end

   //############################
   // shifters
   //############################

   spi_rx_shift u_rx (
      .sclk     (sclk),
      .ss       (ss),
      .shift    (spi_en),
      .lsbfirst (lsbfirst),
      .din      (mosi),
      .rx_byte  (rx_byte)
   );

   // reloads at every byte boundary, even in write bursts
   spi_tx_shift u_tx (
      .sclk     (sclk),
      .ss       (ss),
      .load     (byte_done),
      .shift    (spi_en),
      .lsbfirst (lsbfirst),
      .din      (spi_rdata),
      .dout     (tx_dout)
   );

   //############################
   // regfile strobes and miso
   //############################

   assign spi_write = byte_done & spi_en & (state == SPI_DATA) & (op_reg == SPI_WR);
   assign spi_addr  = addr_reg;
   assign spi_wdata = rx_byte;   // includes the live mosi bit

   // look one byte ahead, tx loads on the completing edge
   assign spi_raddr = (state == SPI_DATA) ? addr_reg + ADDR_W'(1) : rx_byte[ADDR_W-1:0];

   assign rd_active = spi_en & (state == SPI_DATA) & (op_reg == SPI_RD);
   assign miso      = tx_dout & rd_active;   // idle state keeps it low in reset

endmodule

`default_nettype wire

// ==== spi_slave_pkg.sv ====
//############################
// shared widths, opcodes and FSM states for the SPI slave
// command byte is {op[1:0], addr[5:0]}, opcode in the top bits
// opcodes other than write/read are ignored by the slave
//############################

`default_nettype none

package spi_slave_pkg;

   //############################
   // widths
   //############################

   localparam int BYTE_W = 8;        // bus byte and register width
   localparam int ADDR_W = 6;        // address field of the command
   localparam int OP_W   = 2;        // opcode field of the command

   //############################
   // opcodes
   //############################

   localparam logic [OP_W-1:0] SPI_WR = 2'b00;   // burst write
   localparam logic [OP_W-1:0] SPI_RD = 2'b10;   // burst read

   // transaction FSM
   typedef enum logic [1:0] {
      SPI_IDLE,   // ss high, or before the first edge
      SPI_CMD,    // shifting the command byte
      SPI_DATA    // data bytes until ss rises
   } spi_state_t;

endpackage

`default_nettype wire

// ==== spi_slave_top.sv ====
//############################
// SPI slave with byte register file
// single clock domain, everything on rising sclk (mode 0)
// ss is active high, high means deselected and reset
// SREGS sets the regfile size (16/32/64)
//############################

`timescale 1ns/1ps
`default_nettype none

module spi_slave_top #(
   parameter int SREGS = 16
) (
   input  wire  sclk,
   input  wire  ss,
   input  wire  mosi,
   input  wire  spi_en,     // gates shifting, writes and miso
   input  wire  lsbfirst,   // bit order, both directions
   output logic miso
);

   import spi_slave_pkg::*;

   // io block to regfile
   logic              spi_write;
   logic [ADDR_W-1:0] spi_addr;
   logic [BYTE_W-1:0] spi_wdata;
   logic [ADDR_W-1:0] spi_raddr;
   logic [BYTE_W-1:0] spi_rdata;   // comb read data back

   //############################
   // transaction logic
   //############################

   spi_slave_io u_io (
      .sclk      (sclk),
      .ss        (ss),
      .mosi      (mosi),
      .miso      (miso),
      .spi_en    (spi_en),
      .lsbfirst  (lsbfirst),
      .spi_write (spi_write),
      .spi_addr  (spi_addr),
      .spi_wdata (spi_wdata),
      .spi_raddr (spi_raddr),
      .spi_rdata (spi_rdata)
   );

   //############################
   // register file
   //############################

   spi_regfile #(
      .SREGS (SREGS)
   ) u_regs (
      .sclk      (sclk),
      .spi_write (spi_write),
      .spi_addr  (spi_addr),
      .spi_wdata (spi_wdata),
      .spi_raddr (spi_raddr),
      .spi_rdata (spi_rdata)
   );

endmodule

`default_nettype wire

// ==== spi_tx_shift.sv ====
//############################
// loadable serializer for miso
// load wins over shift on the same edge
// first bit is visible right after the load edge
// output is not gated here, the caller does that
//############################

`timescale 1ns/1ps
`default_nettype none

module spi_tx_shift (
   input  wire                              sclk,
   input  wire                              ss,        // async clear
   input  wire                              load,      // take din this edge
   input  wire                              shift,     // advance one bit
   input  wire                              lsbfirst,
   input  wire [spi_slave_pkg::BYTE_W-1:0]  din,
   output logic                             dout
);

   import spi_slave_pkg::*;

   logic [BYTE_W-1:0] sreg;

   //############################
   // shift register
   //############################

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         sreg <= '0;
      end else if (load) begin
         sreg <= din;                          // new byte from regfile
      end else if (shift) begin
         if (lsbfirst)
            sreg <= {1'b0, sreg[BYTE_W-1:1]};   // next bit moves into bit 0
         else
            sreg <= {sreg[BYTE_W-2:0], 1'b0};   // next bit moves into msb
      end
   end

   //############################
   // output bit
   //############################

   // pick the end the bits are walking toward
   assign dout = lsbfirst ? sreg[0] : sreg[BYTE_W-1];

endmodule

`default_nettype wire

// ==== tb_spi_slave.sv ====
//############################
// SPI slave testbench, one transaction per table row
// master drives on rising sclk, slave samples on the next one
// reads only touch registers written earlier in the table
//############################

`timescale 1ns/1ps
`default_nettype none

module tb_spi_slave;

   import spi_slave_pkg::*;

   localparam int SREGS = 16;
   localparam int NROWS = 15;

   typedef struct packed {
      logic [OP_W-1:0]   op;
      logic [ADDR_W-1:0] addr;
      logic              lsb;
      logic              en;
      logic [2:0]        nbytes;   // data bytes, 1 to 4
      logic [2:0]        cut;      // bits dropped from the last byte
      logic              rnd;      // random data instead of the column below
      logic [31:0]       data;     // first byte in [31:24]
   } row_t;

   logic        sclk = 1'b0;
   logic        ss;
   logic        mosi;
   logic        spi_en;
   logic        lsbfirst;
   wire         miso;
   int          checks;
   int          errors;
   int          cycles = 0;
   int          limit  = 0;
   logic        run_done = 1'b0;
   logic [31:0] seed_word;
   row_t        rows [NROWS];

   spi_slave_top #(.SREGS(SREGS)) DUT (
      .sclk     (sclk),
      .ss       (ss),
      .mosi     (mosi),
      .spi_en   (spi_en),
      .lsbfirst (lsbfirst),
      .miso     (miso)
   );

   spi_slave_checker #(.SREGS(SREGS)) u_chk (
      .sclk     (sclk),
      .ss       (ss),
      .mosi     (mosi),
      .miso     (miso),
      .spi_en   (spi_en),
      .lsbfirst (lsbfirst),
      .checks   (checks),
      .errors   (errors)
   );

   always #10 sclk = ~sclk;   // 20 ns period

   //############################
   // stimulus table
   //############################

   task automatic load_table();
      //            op      addr   lsb   en    n     cut   rnd   data
      rows[0]  = '{SPI_WR, 6'h02, 1'b0, 1'b1, 3'd4, 3'd0, 1'b0, 32'hA53C0F81};
      rows[1]  = '{SPI_RD, 6'h02, 1'b0, 1'b1, 3'd4, 3'd0, 1'b0, 32'h0};
      rows[2]  = '{SPI_WR, 6'h06, 1'b1, 1'b1, 3'd4, 3'd0, 1'b1, 32'h0};
      rows[3]  = '{SPI_RD, 6'h06, 1'b1, 1'b1, 3'd4, 3'd0, 1'b0, 32'h0};
      rows[4]  = '{SPI_RD, 6'h02, 1'b1, 1'b1, 3'd4, 3'd0, 1'b0, 32'h0};   // bits reversed
      rows[5]  = '{SPI_WR, 6'h0E, 1'b0, 1'b1, 3'd4, 3'd0, 1'b1, 32'h0};   // wraps to 0
      rows[6]  = '{SPI_RD, 6'h30, 1'b0, 1'b1, 3'd2, 3'd0, 1'b0, 32'h0};   // index 0
      rows[7]  = '{SPI_RD, 6'h0E, 1'b1, 1'b1, 3'd4, 3'd0, 1'b0, 32'h0};
      rows[8]  = '{SPI_WR, 6'h02, 1'b0, 1'b0, 3'd2, 3'd0, 1'b0, 32'hFFFF0000};
      rows[9]  = '{SPI_RD, 6'h02, 1'b0, 1'b1, 3'd2, 3'd0, 1'b0, 32'h0};
      rows[10] = '{2'b01,  6'h03, 1'b0, 1'b1, 3'd2, 3'd0, 1'b0, 32'h5A5A0000};
      rows[11] = '{2'b11,  6'h02, 1'b1, 1'b1, 3'd1, 3'd0, 1'b0, 32'h77000000};
      rows[12] = '{SPI_RD, 6'h02, 1'b0, 1'b1, 3'd4, 3'd0, 1'b0, 32'h0};
      rows[13] = '{SPI_WR, 6'h07, 1'b0, 1'b1, 3'd3, 3'd3, 1'b0, 32'h11223300};
      rows[14] = '{SPI_RD, 6'h07, 1'b0, 1'b1, 3'd3, 3'd0, 1'b0, 32'h0};
   endtask

   function automatic int run_length();
      int total;
      total = 50;
      for (int i = 0; i < NROWS; i++)
         total += 8 + 8 * int'(rows[i].nbytes) + 2;
      return total;
   endfunction

   // ss low, command plus data bits, then ss high for two cycles
   task automatic run_row(input row_t r);
      logic [BYTE_W-1:0] bytes [5];
      logic [31:0]       rnd_word;
      int                nbits;
      int                bi;
      bytes[0] = {r.op, r.addr};
      for (int k = 0; k < 4; k++) begin
         rnd_word   = $urandom();
         bytes[k+1] = r.rnd ? rnd_word[7:0] : r.data[31-8*k -: 8];
      end
      nbits = BYTE_W * (1 + int'(r.nbytes)) - int'(r.cut);
      for (int i = 0; i < nbits; i++) begin
         bi = r.lsb ? i % BYTE_W : BYTE_W - 1 - i % BYTE_W;
         @(posedge sclk);
         if (i == 0) begin
            ss       <= 1'b0;
            spi_en   <= r.en;
            lsbfirst <= r.lsb;
         end
         mosi <= bytes[i / BYTE_W][bi];
      end
      @(posedge sclk);
      ss   <= 1'b1;   // also aborts a cut byte
      mosi <= 1'b0;
      @(posedge sclk);
   endtask

   //############################
   // run control
   //############################

   always @(posedge sclk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         run_done = 1'b1;
         $display("timeout: run not finished after %0d cycles, %0d checks, %0d errors",
                  limit, checks, errors + DUT.u_io.u_asserts.fails);
         $display("** FAIL **");
         $finish;
      end
   end

   initial begin
      seed_word = $urandom(32'hecb0);
      ss        = 1'b1;
      mosi      = 1'b0;
      spi_en    = 1'b0;
      lsbfirst  = 1'b0;
      load_table();
      limit = run_length();
      repeat (3) @(posedge sclk);   // reset
      for (int i = 0; i < NROWS; i++)
         run_row(rows[i]);
      repeat (2) @(posedge sclk);
      run_done = 1'b1;
      $display("closing: %0d checks, %0d errors, %0d assertion failures",
               checks, errors, DUT.u_io.u_asserts.fails);
      if (errors == 0 && DUT.u_io.u_asserts.fails == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   // stopped before the table was done
   final begin
      if (!run_done)
         $display("** FAIL **");
   end

endmodule

`default_nettype wire
